//--- rtl/div_config.svh
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// Operand width of the divider in bits, 8, 16 and 32 are supported
`define DIVLEN 16

// Step counter width, which must be able to hold DIVLEN+1
`define DURLEN ($clog2(`DIVLEN + 2))

`endif

//--- rtl/divPkg.sv
package divPkg;

  //////////////////////////////////////////////////////////////////////
  // Controller state
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    StIdle,
    StBusy,
    StDone
  } divState;

  //////////////////////////////////////////////////////////////////////
  // Signed radix-2 quotient digit
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    DigitZero,
    DigitPlus,
    DigitMinus
  } qDigit;

endpackage

//--- rtl/divPreproc.sv
`include "div_config.svh"

module divPreproc import divPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load,
  input  logic [`DIVLEN-1:0]   dividend,
  input  logic [`DIVLEN-1:0]   divisor,
  output logic [`DIVLEN-1:0]   normDivisor,
  output logic [`DIVLEN-1:0]   regDividend,
  output logic [`DURLEN-1:0]   normShift,
  output logic                 divZero,
  output logic                 dividendZero,
  output logic                 specialCase
);

  localparam int divLen = `DIVLEN;
  localparam int durLen = `DURLEN;

  logic [divLen-1:0] liveNorm;
  logic [divLen-1:0] heldNorm;
  logic [durLen-1:0] liveShift;
  logic [durLen-1:0] heldShift;
  logic              liveSpecial;

  // Leading zero count, a zero divisor counts as divLen
  function automatic logic [durLen-1:0] countLz(input logic [divLen-1:0] value);
    logic [durLen-1:0] count;
    logic              found;
    count = durLen'(divLen);
    found = 1'b0;
    for (int i = divLen - 1; i >= 0; i--) begin
      if (!found && value[i]) begin
        count = durLen'(divLen - 1 - i);
        found = 1'b1;
      end
    end
    return count;
  endfunction

  assign liveShift   = countLz(divisor);
  // Top bit set after this shift unless the divisor is zero
  assign liveNorm    = divisor << liveShift;
  assign liveSpecial = (divisor == '0) || (dividend == '0);

  always_ff @(posedge clk) begin
    if (load) begin
      heldNorm    <= liveNorm;
      heldShift   <= liveShift;
      regDividend <= dividend;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      divZero      <= 1'b0;
      dividendZero <= 1'b0;
    end else if (load) begin
      divZero      <= (divisor == '0);
      dividendZero <= (dividend == '0);
    end
  end

  // In the load cycle the live values pass straight through so the
  // iteration registers and the controller can start on the same edge
  assign normDivisor = load ? liveNorm : heldNorm;
  assign normShift   = load ? liveShift : heldShift;
  assign specialCase = load ? liveSpecial : (divZero | dividendZero);

endmodule

//--- rtl/srtIter.sv
`include "div_config.svh"

module srtIter import divPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load,
  input  logic                 iterate,
  input  logic [`DIVLEN-1:0]   dividend,
  input  logic [`DIVLEN-1:0]   normDivisor,
  input  logic [`DURLEN-1:0]   normShift,
  output logic [`DIVLEN+3:0]   sum,
  output logic [`DIVLEN+3:0]   carry,
  output logic [`DIVLEN+3:0]   nextSum,
  output logic [`DIVLEN+3:0]   nextCarry,
  output qDigit                digit
);

  localparam int divLen  = `DIVLEN;
  localparam int wordLen = `DIVLEN + 4;

  logic [2*divLen-1:0]  scaled;
  logic [divLen:0]      feed;
  logic                 bitIn;
  logic                 pending;
  logic [wordLen-1:0]   ys;
  logic [wordLen-1:0]   yc;
  logic [wordLen-1:0]   addend;
  logic [wordLen-1:0]   csaSum;
  logic [wordLen-1:0]   csaMaj;
  logic [wordLen-1:0]   csaCarry;
  logic [3:0]           estimate;

  // Dividend scaled by the same shift as the divisor. The upper part
  // forms the first residual and the low divLen+1 bits enter one per step
  assign scaled  = {{divLen{1'b0}}, dividend} << normShift;
  assign bitIn   = feed[divLen];
  assign pending = |feed[divLen-1:0];

  // Doubled residual with the next dividend bit in the free LSB
  assign ys = {sum[wordLen-2:0], bitIn};
  assign yc = {carry[wordLen-2:0], 1'b0};

  // Estimate with one fraction bit, the divisor weight is 1/2 at bit divLen-1
  assign estimate = ys[divLen+2:divLen-1] + yc[divLen+2:divLen-1];

  always_comb begin
    if (!estimate[3]) digit = DigitPlus;
    else if (estimate == 4'b1111) digit = DigitZero;
    else digit = DigitMinus;
  end

  always_comb begin
    case (digit)
      DigitPlus:  addend = ~{4'b0000, normDivisor};
      DigitMinus: addend = {4'b0000, normDivisor};
      default:    addend = '0;
    endcase
  end

  // Carry-save add, the two's complement +1 goes into the empty carry LSB
  assign csaSum   = ys ^ yc ^ addend;
  assign csaMaj   = (ys & yc) | (ys & addend) | (yc & addend);
  assign csaCarry = {csaMaj[wordLen-2:0], (digit == DigitPlus)};

  // Dividend bits still waiting to enter make the true residual nonzero
  assign nextSum   = pending ? '1 : csaSum;
  assign nextCarry = pending ? '0 : csaCarry;

  always_ff @(posedge clk) begin
    if (reset) begin
      sum   <= '0;
      carry <= '0;
      feed  <= '0;
    end else if (load) begin
      sum   <= {5'b00000, scaled[2*divLen-1:divLen+1]};
      carry <= '0;
      feed  <= scaled[divLen:0];
    end else if (iterate) begin
      sum   <= csaSum;
      carry <= csaCarry;
      feed  <= {feed[divLen-1:0], 1'b0};
    end
  end

endmodule

//--- rtl/quotConv.sv
`include "div_config.svh"

module quotConv import divPkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              iterate,
  input  qDigit             digit,
  output logic [`DIVLEN:0]  quot,
  output logic [`DIVLEN:0]  quotM
);

  localparam int divLen = `DIVLEN;

  // On-the-fly conversion keeps quot and quot-1 as plain binary so the
  // final correction is only a select
  always_ff @(posedge clk) begin
    if (reset || load) begin
      quot  <= '0;
      quotM <= '0;
    end else if (iterate) begin
      case (digit)
        DigitPlus: begin
          quot  <= {quot[divLen-1:0], 1'b1};
          quotM <= {quot[divLen-1:0], 1'b0};
        end
        DigitMinus: begin
          quot  <= {quotM[divLen-1:0], 1'b1};
          quotM <= {quotM[divLen-1:0], 1'b0};
        end
        default: begin
          quot  <= {quot[divLen-1:0], 1'b0};
          quotM <= {quotM[divLen-1:0], 1'b1};
        end
      endcase
    end
  end

endmodule

//--- rtl/srtFsm.sv
`include "div_config.svh"

module srtFsm import divPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic                 stall,
  input  logic                 specialCase,
  input  logic [`DIVLEN+3:0]   nextSum,
  input  logic [`DIVLEN+3:0]   nextCarry,
  input  logic [`DIVLEN+3:0]   sum,
  input  logic [`DIVLEN+3:0]   carry,
  output logic                 load,
  output logic                 iterate,
  output logic                 busy,
  output logic                 done,
  output logic                 sticky,
  output logic                 negResidual,
  output logic [`DURLEN-1:0]   earlyShift
);

  localparam int wordLen = `DIVLEN + 4;
  localparam int durLen  = `DURLEN;

  divState            state;
  logic [durLen-1:0]  step;
  logic               nextZero;
  logic               curZero;
  logic [wordLen-1:0] residual;

  // a+b is zero modulo 2^n exactly when a^b equals (a|b) shifted left by one
  assign nextZero = (nextSum ^ nextCarry) ==
                    {nextSum[wordLen-2:0] | nextCarry[wordLen-2:0], 1'b0};
  assign curZero  = (sum ^ carry) == {sum[wordLen-2:0] | carry[wordLen-2:0], 1'b0};

  assign residual    = sum + carry;
  assign negResidual = residual[wordLen-1];
  assign sticky      = ~curZero;

  assign load       = start & ~stall & (state == StIdle);
  assign busy       = (state == StBusy);
  assign iterate    = busy;
  assign done       = (state == StDone);
  assign earlyShift = step;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= StIdle;
      step  <= '0;
    end else begin
      case (state)
        StIdle: if (load) begin
          step  <= durLen'(`DIVLEN + 1);
          state <= specialCase ? StDone : StBusy;
        end
        StBusy: begin
          // Steps left after this one stay in step for the quotient shift
          step <= step - 1'b1;
          if (step == durLen'(1) || nextZero) state <= StDone;
        end
        StDone: if (!stall) state <= StIdle;
        default: state <= StIdle;
      endcase
    end
  end

endmodule

//--- rtl/divPost.sv
`include "div_config.svh"

module divPost import divPkg::*; (
  input  logic [`DIVLEN:0]     quot,
  input  logic [`DIVLEN:0]     quotM,
  input  logic [`DIVLEN+3:0]   sum,
  input  logic [`DIVLEN+3:0]   carry,
  input  logic [`DIVLEN-1:0]   normDivisor,
  input  logic [`DIVLEN-1:0]   regDividend,
  input  logic [`DURLEN-1:0]   normShift,
  input  logic [`DURLEN-1:0]   earlyShift,
  input  logic                 negResidual,
  input  logic                 sticky,
  input  logic                 divZero,
  input  logic                 dividendZero,
  output logic [`DIVLEN-1:0]   quotient,
  output logic [`DIVLEN-1:0]   remainder
);

  localparam int divLen  = `DIVLEN;
  localparam int wordLen = `DIVLEN + 4;

  logic [wordLen-1:0] residual;
  logic [wordLen-1:0] fixedResidual;
  logic [divLen:0]    quotSel;
  logic [divLen:0]    quotShifted;
  logic [divLen-1:0]  remShifted;

  ///////////////////////////////////////////////////////////////////////
  // Negative residual correction
  ///////////////////////////////////////////////////////////////////////

  assign residual      = sum + carry;
  // A negative residual means the last digit overshot by one divisor
  assign fixedResidual = negResidual ? residual + {4'b0000, normDivisor} : residual;
  assign quotSel       = negResidual ? quotM : quot;

  // Digits skipped after an early end are all zero
  assign quotShifted = quotSel << earlyShift;
  // Remainder was carried scaled by the divisor normalization
  assign remShifted  = fixedResidual[divLen-1:0] >> normShift;

  ///////////////////////////////////////////////////////////////////////
  // Result select
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    if (divZero) begin
      quotient  = '1;
      remainder = regDividend;
    end else if (dividendZero) begin
      quotient  = '0;
      remainder = '0;
    end else begin
      quotient  = quotShifted[divLen-1:0];
      remainder = sticky ? remShifted : '0;
    end
  end

endmodule

//--- rtl/divUnit.sv
`include "div_config.svh"

module divUnit (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                stall,
  input  logic [`DIVLEN-1:0]  dividend,
  input  logic [`DIVLEN-1:0]  divisor,
  output logic [`DIVLEN-1:0]  quotient,
  output logic [`DIVLEN-1:0]  remainder,
  output logic                busy,
  output logic                done
);

  logic                load;
  logic                iterate;
  logic                specialCase;
  logic                sticky;
  logic                negResidual;
  logic                divZero;
  logic                dividendZero;
  logic [`DIVLEN-1:0]  normDivisor;
  logic [`DIVLEN-1:0]  regDividend;
  logic [`DURLEN-1:0]  normShift;
  logic [`DURLEN-1:0]  earlyShift;
  logic [`DIVLEN+3:0]  sum;
  logic [`DIVLEN+3:0]  carry;
  logic [`DIVLEN+3:0]  nextSum;
  logic [`DIVLEN+3:0]  nextCarry;
  logic [`DIVLEN:0]    quot;
  logic [`DIVLEN:0]    quotM;
  divPkg::qDigit       digit;

  // Controller
  srtFsm fsm (.clk, .reset, .start, .stall, .specialCase, .nextSum, .nextCarry, .sum,
    .carry, .load, .iterate, .busy, .done, .sticky, .negResidual, .earlyShift);

  // Operand capture and divisor normalization
  divPreproc pre (.clk, .reset, .load, .dividend, .divisor, .normDivisor, .regDividend,
    .normShift, .divZero, .dividendZero, .specialCase);

  // Residual recurrence, it starts from the raw dividend on the load edge
  srtIter iter (.clk, .reset, .load, .iterate, .dividend, .normDivisor, .normShift,
    .sum, .carry, .nextSum, .nextCarry, .digit);

  quotConv conv (.clk, .reset, .load, .iterate, .digit, .quot, .quotM);

  divPost post (.quot, .quotM, .sum, .carry, .normDivisor, .regDividend, .normShift,
    .earlyShift, .negResidual, .sticky, .divZero, .dividendZero, .quotient, .remainder);

endmodule

//--- sim/div_assertions.sv
`include "div_config.svh"

module divAssertions (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic busy,
  input logic done
);

  timeunit 1ns;
  timeprecision 1ps;

  // Length of the current busy stretch in cycles
  logic [7:0] busyRun;

  always_ff @(posedge clk) begin
    if (reset || !busy) begin
      busyRun <= '0;
    end else begin
      busyRun <= busyRun + 8'd1;
    end
  end

  // Without stall the result is offered for a single cycle
  donePulse: assert property (@(posedge clk) disable iff (reset) (done && !stall) |=> !done)
    else $error("done stayed high after a cycle with stall low");

  // A raised stall keeps the result on the outputs
  doneHeldByStall: assert property (@(posedge clk) disable iff (reset) (done && stall) |=> done)
    else $error("done dropped while stall was high");

  idleAfterReset: assert property (@(posedge clk) reset |=> (!busy && !done))
    else $error("busy or done high right after reset");

  // One step per quotient bit plus the extra integer step at most
  busyBounded: assert property (@(posedge clk) disable iff (reset) busyRun <= (`DIVLEN + 1))
    else $error("busy lasted longer than DIVLEN+1 cycles");

endmodule

bind divUnit divAssertions assertions (.clk, .reset, .stall, .busy, .done);

//--- sim/divTb.sv
`include "div_config.svh"

module divTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int divLen     = `DIVLEN;
  localparam int numRandom  = 200;

  logic              clk;
  logic              reset;
  logic              start;
  logic              stall;
  logic [divLen-1:0] dividend;
  logic [divLen-1:0] divisor;
  logic [divLen-1:0] quotient;
  logic [divLen-1:0] remainder;
  logic              busy;
  logic              done;

  // Watchdog budget in clock cycles, zero until the case count is known
  int limitCycles = 0;

  divUnit dut (.clk, .reset, .start, .stall, .dividend, .divisor, .quotient, .remainder,
    .busy, .done);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking and case sequencing
  //////////////////////////////////////////////////////////////////////

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // One division from start pulse to the fall of done
  task automatic runCase(input logic [divLen-1:0] a, input logic [divLen-1:0] b,
                         input int stallCycles, input logic [divLen-1:0] expQ,
                         input logic [divLen-1:0] expR);
    int                busyCount;
    bit                sawDone;
    bit                secondStart;
    logic [divLen-1:0] heldQ;
    logic [divLen-1:0] heldR;
    busyCount = 0;
    sawDone   = 1'b0;
    @(posedge clk);
    start    <= 1'b1;
    dividend <= a;
    divisor  <= b;
    @(posedge clk);
    // The DUT loads on this edge, stall may rise now since it only matters in done
    start <= 1'b0;
    stall <= (stallCycles > 0);
    while (!sawDone) begin
      @(negedge clk);
      if (done) begin
        sawDone = 1'b1;
      end else begin
        if (busy) busyCount++;
        // A second start with other operands in the first busy cycle must be ignored
        secondStart = busy && (busyCount == 1);
        @(posedge clk);
        start <= secondStart;
        if (secondStart) begin
          dividend <= ~a;
          divisor  <= ~b;
        end
      end
    end
    checkEq(quotient, expQ, "quotient");
    checkEq(remainder, expR, "remainder");
    checkEq(busyCount <= divLen + 1, 1'b1, "busy length");
    if (a == '0 || b == '0) checkEq(busyCount, 0, "busy count on a special case");
    heldQ = quotient;
    heldR = remainder;
    // Keep stall high over done, dropping it on the last held cycle
    for (int i = 1; i <= stallCycles; i++) begin
      @(posedge clk);
      start <= 1'b0;
      stall <= (i < stallCycles);
      @(negedge clk);
      checkEq(done, 1'b1, "done under stall");
      checkEq(quotient, heldQ, "quotient under stall");
      checkEq(remainder, heldR, "remainder under stall");
    end
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    checkEq(done, 1'b0, "done after stall low");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                fd;
    int                fields;
    int                maxStall;
    int                s;
    string             line;
    logic [divLen-1:0] a;
    logic [divLen-1:0] b;
    logic [divLen-1:0] q;
    logic [divLen-1:0] r;
    logic [divLen-1:0] fileA[$];
    logic [divLen-1:0] fileB[$];
    logic [divLen-1:0] fileQ[$];
    logic [divLen-1:0] fileR[$];
    int                fileStall[$];

    reset    = 1'b1;
    start    = 1'b0;
    stall    = 1'b0;
    dividend = '0;
    divisor  = '0;
    void'($urandom(11));

    fd = $fopen("sim/div_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file sim/div_stim.txt");
      $display("TESTS FAILED");
      $fatal(1, "missing stimulus");
    end
    maxStall = 2;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      // Lines starting with # describe the columns
      if (line.len() > 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h", a, b, s, q, r);
        if (fields == 5) begin
          fileA.push_back(a);
          fileB.push_back(b);
          fileStall.push_back(s);
          fileQ.push_back(q);
          fileR.push_back(r);
          if (s > maxStall) maxStall = s;
        end
      end
    end
    $fclose(fd);

    limitCycles = (fileA.size() + numRandom) * (divLen + 8 + maxStall) + 20;

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    foreach (fileA[i]) begin
      runCase(fileA[i], fileB[i], fileStall[i], fileQ[i], fileR[i]);
    end

    // Divisors of every size come from a random right shift
    for (int i = 0; i < numRandom; i++) begin
      a = divLen'($urandom);
      b = divLen'($urandom >> ($urandom % 32));
      s = $urandom % 3;
      if (b == '0) begin
        q = '1;
        r = a;
      end else begin
        q = a / b;
        r = a % b;
      end
      runCase(a, b, s, q, r);
    end

    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("The run hung waiting for done after %0d cycles", limitCycles);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- sim/div_stim.txt
# Columns: dividend divisor stallCycles quotient remainder, all hex
# Operands are DIVLEN=16 bits wide
0064 0007 0 000e 0002
ffff 0001 2 ffff 0000
ffff ffff 0 0001 0000
1234 0000 3 ffff 1234
0000 0005 1 0000 0000
0000 0000 0 ffff 0000
0c00 0040 0 0030 0000
fffe 0002 0 7fff 0000
8000 0003 0 2aaa 0002
0007 0009 0 0000 0007
abcd 0100 1 00ab 00cd
7fff 00ff 0 0080 007f
1000 0010 2 0100 0000
ffff 8000 0 0001 7fff
0001 0001 4 0001 0000
9c40 03e8 0 0028 0000
3039 007b 0 0064 002d
fedc 0001 0 fedc 0000
00c8 0019 1 0008 0000
0005 0003 0 0001 0002

//--- build.f
+incdir+rtl
rtl/divPkg.sv
rtl/divPreproc.sv
rtl/srtIter.sv
rtl/quotConv.sv
rtl/srtFsm.sv
rtl/divPost.sv
rtl/divUnit.sv
sim/div_assertions.sv
sim/divTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f build.f --top-module divTb -o simDiv
./obj_dir/simDiv
